// ==== Bender.yml ====
package:
  name: exu

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/exu_ctrl_pkg.sv
      - logic/exu_data_pkg.sv
      - logic/exu_operand_stage.sv
      - logic/exu_alu_branch.sv
      - logic/div_ctrl_fsm.sv
      - logic/div_step_counter.sv
      - logic/div_datapath.sv
      - logic/exu_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tb/exu_checker.sv
      - tb/exu_tb.sv

// ==== logic/div_ctrl_fsm.sv ====
module div_ctrl_fsm (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     start,
    input  logic                     abort,
    input  logic                     last_step,
    input  logic                     ready_ex_mem,
    output exu_ctrl_pkg::div_state_t state
);

    exu_ctrl_pkg::div_state_t state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            // wait for a division that memory can accept
            exu_ctrl_pkg::DIV_IDLE: begin
                if (start) begin
                    state_nxt = exu_ctrl_pkg::DIV_RUN;
                end
            end
            // one quotient bit per cycle
            exu_ctrl_pkg::DIV_RUN: begin
                if (last_step) begin
                    state_nxt = exu_ctrl_pkg::DIV_DONE;
                end
            end
            // result held until memory takes it
            exu_ctrl_pkg::DIV_DONE: begin
                if (ready_ex_mem) begin
                    state_nxt = exu_ctrl_pkg::DIV_IDLE;
                end
            end
            default: state_nxt = exu_ctrl_pkg::DIV_IDLE;
        endcase
        // flush kills the division in any state
        if (abort) begin
            state_nxt = exu_ctrl_pkg::DIV_IDLE;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= exu_ctrl_pkg::DIV_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

endmodule

// ==== logic/div_datapath.sv ====
`include "exu_settings.svh"

module div_datapath (
    input  logic                     clk,
    input  logic                     arst_n,
    input  exu_ctrl_pkg::div_state_t state,
    input  exu_data_pkg::xlen_t      dividend,
    input  exu_data_pkg::xlen_t      divisor,
    output exu_data_pkg::xlen_t      quotient,
    output exu_data_pkg::xlen_t      remainder
);

    exu_data_pkg::xlen_t   dsr_q;
    // partial remainder widened by one bit for the trial subtract
    logic [`EXU_XLEN:0]    partial;
    logic [`EXU_XLEN:0]    diff;

    // shift next dividend bit out of the quotient register
    assign partial = {remainder, quotient[`EXU_XLEN-1]};
    assign diff    = partial - {1'b0, dsr_q};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            quotient  <= '0;
            remainder <= '0;
            dsr_q     <= '0;
        end else if (state == exu_ctrl_pkg::DIV_IDLE) begin
            // track the operands until the run starts
            // quotient reg doubles as dividend shifter
            quotient  <= dividend;
            remainder <= '0;
            dsr_q     <= divisor;
        end else if (state == exu_ctrl_pkg::DIV_RUN) begin
            if (!diff[`EXU_XLEN]) begin
                // subtract fits, quotient bit is one
                remainder <= diff[`EXU_XLEN-1:0];
                quotient  <= {quotient[`EXU_XLEN-2:0], 1'b1};
            end else begin
                // restore, quotient bit is zero
                remainder <= partial[`EXU_XLEN-1:0];
                quotient  <= {quotient[`EXU_XLEN-2:0], 1'b0};
            end
        end
        // done state holds the result
    end

endmodule

// ==== logic/div_step_counter.sv ====
`include "exu_settings.svh"

module div_step_counter (
    input  logic                     clk,
    input  logic                     arst_n,
    input  exu_ctrl_pkg::div_state_t state,
    output logic                     last_step
);

    // must hold the full step count, not just count-1
    logic [$clog2(`EXU_DIV_STEPS+1)-1:0] steps_left;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            steps_left <= `EXU_DIV_STEPS;
        end else if (state == exu_ctrl_pkg::DIV_IDLE) begin
            // preload so the first run cycle already counts
            steps_left <= `EXU_DIV_STEPS;
        end else if (state == exu_ctrl_pkg::DIV_RUN) begin
            steps_left <= steps_left - 1'b1;
        end
    end

    // final shift-subtract happens in this cycle
    assign last_step = (state == exu_ctrl_pkg::DIV_RUN) && (steps_left == 1);

endmodule

// ==== logic/exu_alu_branch.sv ====
`include "exu_settings.svh"

module exu_alu_branch (
    input  exu_data_pkg::issue_t cur,
    input  exu_data_pkg::xlen_t  op_a,
    input  exu_data_pkg::xlen_t  op_b_reg,
    output exu_data_pkg::xlen_t  alu_value,
    output logic                 taken,
    output exu_data_pkg::xlen_t  dnpc
);

    exu_data_pkg::xlen_t op_b;
    exu_data_pkg::xlen_t snpc;
    exu_data_pkg::xlen_t br_target;
    logic [5:0]          shamt;
    logic                eq;
    logic                lt_s;
    logic                lt_u;
    logic                b_lt_s;
    logic                b_lt_u;

    // register or immediate form
    assign op_b  = cur.use_imm ? cur.imm : op_b_reg;
    // rv64 shifts use six bits of the amount
    assign shamt = op_b[5:0];
    assign snpc  = cur.pc + exu_data_pkg::xlen_t'(`EXU_PC_STEP);
    assign br_target = cur.pc + cur.imm;

    // set-less-than on the selected operand b
    assign lt_s = $signed(op_a) < $signed(op_b);
    assign lt_u = op_a < op_b;

    // branch compares always take rs2
    assign eq     = op_a == op_b_reg;
    assign b_lt_s = $signed(op_a) < $signed(op_b_reg);
    assign b_lt_u = op_a < op_b_reg;

    always_comb begin
        alu_value = '0;
        taken     = 1'b0;
        dnpc      = snpc;
        case (cur.op)
            exu_ctrl_pkg::OP_ADD:  alu_value = op_a + op_b;
            exu_ctrl_pkg::OP_SUB:  alu_value = op_a - op_b;
            exu_ctrl_pkg::OP_AND:  alu_value = op_a & op_b;
            exu_ctrl_pkg::OP_OR:   alu_value = op_a | op_b;
            exu_ctrl_pkg::OP_XOR:  alu_value = op_a ^ op_b;
            exu_ctrl_pkg::OP_SLL:  alu_value = op_a << shamt;
            exu_ctrl_pkg::OP_SRL:  alu_value = op_a >> shamt;
            exu_ctrl_pkg::OP_SRA:  alu_value = $signed(op_a) >>> shamt;
            exu_ctrl_pkg::OP_SLT:  alu_value = exu_data_pkg::xlen_t'(lt_s);
            exu_ctrl_pkg::OP_SLTU: alu_value = exu_data_pkg::xlen_t'(lt_u);
            // not-taken branches fall through to snpc
            exu_ctrl_pkg::OP_BEQ:  taken = eq;
            exu_ctrl_pkg::OP_BNE:  taken = !eq;
            exu_ctrl_pkg::OP_BLT:  taken = b_lt_s;
            exu_ctrl_pkg::OP_BGE:  taken = !b_lt_s;
            exu_ctrl_pkg::OP_BLTU: taken = b_lt_u;
            exu_ctrl_pkg::OP_BGEU: taken = !b_lt_u;
            exu_ctrl_pkg::OP_JAL: begin
                taken     = 1'b1;
                alu_value = snpc;
            end
            exu_ctrl_pkg::OP_JALR: begin
                taken     = 1'b1;
                alu_value = snpc;
                dnpc      = op_a + cur.imm;
            end
            // divu/remu value comes from the divider
            default: alu_value = '0;
        endcase
        // pc-relative target for jal and taken branches
        if (taken && cur.op != exu_ctrl_pkg::OP_JALR) begin
            dnpc = br_target;
        end
    end

endmodule

// ==== logic/exu_ctrl_pkg.sv ====
package exu_ctrl_pkg;

    // operations the execute stage understands
    // decode maps funct3/funct7 down to one of these
    typedef enum logic [4:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_SLT,
        OP_SLTU,
        // conditional branches, compare rs1 against rs2
        OP_BEQ,
        OP_BNE,
        OP_BLT,
        OP_BGE,
        OP_BLTU,
        OP_BGEU,
        // unconditional jumps, value is the link address
        OP_JAL,
        OP_JALR,
        // iterative unsigned divider
        OP_DIVU,
        OP_REMU
    } ex_op_t;

    // divider sequencing
    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_DONE
    } div_state_t;

endpackage

// ==== logic/exu_data_pkg.sv ====
`include "exu_settings.svh"

package exu_data_pkg;

    // one data word or one address
    typedef logic [`EXU_XLEN-1:0] xlen_t;

    // architectural register index
    typedef logic [`EXU_REG_W-1:0] reg_idx_t;

    // one decoded instruction handed over by decode
    typedef struct packed {
        xlen_t                 pc;
        exu_ctrl_pkg::ex_op_t  op;
        // operand b comes from imm, rs2 not read
        logic                  use_imm;
        reg_idx_t              rd;
        reg_idx_t              rs1;
        reg_idx_t              rs2;
        // register file values as read in decode
        xlen_t                 src_a;
        xlen_t                 src_b;
        xlen_t                 imm;
    } issue_t;

    // register write of a later stage, used for bypass
    typedef struct packed {
        logic     wen;
        reg_idx_t rd;
        xlen_t    data;
    } fwd_t;

    // bundle passed on to the memory stage
    typedef struct packed {
        xlen_t    pc;
        reg_idx_t rd;
        xlen_t    value;
    } result_t;

endpackage

// ==== logic/exu_operand_stage.sv ====
module exu_operand_stage (
    input  logic                  clk,
    input  logic                  arst_n,
    input  exu_data_pkg::issue_t  issue,
    input  logic                  valid_id_ex,
    input  logic                  ready_id_ex,
    input  logic                  branch_flush,
    input  exu_data_pkg::fwd_t    mem_fwd,
    input  exu_data_pkg::fwd_t    wb_fwd,
    output exu_data_pkg::issue_t  cur,
    output logic                  cur_valid,
    output exu_data_pkg::xlen_t   op_a,
    output exu_data_pkg::xlen_t   op_b_reg
);

    // bypass for one source register
    // mem stage is younger, so it takes priority over write-back
    function automatic exu_data_pkg::xlen_t fwd_pick(
        input exu_data_pkg::reg_idx_t idx,
        input exu_data_pkg::xlen_t    dflt,
        input exu_data_pkg::fwd_t     mem,
        input exu_data_pkg::fwd_t     wb
    );
        exu_data_pkg::xlen_t val;
        val = dflt;
        // x0 never forwarded, always reads zero
        if (idx != '0) begin
            if (mem.wen && mem.rd == idx) begin
                val = mem.data;
            end else if (wb.wen && wb.rd == idx) begin
                val = wb.data;
            end
        end
        return val;
    endfunction

    // valid bit of the execute register
    // flush beats the hold, an empty slot is loaded when ready
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cur_valid <= 1'b0;
        end else if (branch_flush) begin
            cur_valid <= 1'b0;
        end else if (ready_id_ex) begin
            cur_valid <= valid_id_ex;
        end
    end

    // instruction payload, only meaningful with cur_valid
    always_ff @(posedge clk) begin
        if (ready_id_ex) begin
            cur <= issue;
        end
    end

    always_comb begin
        op_a = fwd_pick(cur.rs1, cur.src_a, mem_fwd, wb_fwd);
        // immediate forms leave rs2 alone
        if (cur.use_imm) begin
            op_b_reg = cur.src_b;
        end else begin
            op_b_reg = fwd_pick(cur.rs2, cur.src_b, mem_fwd, wb_fwd);
        end
    end

endmodule

// ==== logic/exu_settings.svh ====
`ifndef EXU_SETTINGS_SVH
`define EXU_SETTINGS_SVH

// width of one data word and of every address
`define EXU_XLEN 64

// architectural register index, 32 integer registers
`define EXU_REG_W 5

// restoring divider retires one quotient bit per step
`define EXU_DIV_STEPS `EXU_XLEN

// sequential pc increment, no compressed instructions
`define EXU_PC_STEP 4

`endif

// ==== logic/exu_top.sv ====
module exu_top (
    input  logic                  clk,
    input  logic                  arst_n,
    input  exu_data_pkg::issue_t  issue,
    input  logic                  valid_id_ex,
    output logic                  ready_id_ex,
    input  exu_data_pkg::fwd_t    mem_fwd,
    input  exu_data_pkg::fwd_t    wb_fwd,
    input  logic                  branch_flush,
    output exu_data_pkg::result_t result,
    output logic                  valid_ex_mem,
    input  logic                  ready_ex_mem,
    output logic                  pc_update,
    output exu_data_pkg::xlen_t   dnpc
);

    exu_data_pkg::issue_t     cur;
    logic                     cur_valid;
    exu_data_pkg::xlen_t      op_a;
    exu_data_pkg::xlen_t      op_b_reg;
    exu_data_pkg::xlen_t      alu_value;
    logic                     taken;
    exu_data_pkg::xlen_t      quotient;
    exu_data_pkg::xlen_t      remainder;
    exu_ctrl_pkg::div_state_t div_state;
    logic                     last_step;
    logic                     is_div;
    logic                     div_pending;
    logic                     div_start;

    exu_operand_stage u_operand (
        .clk          (clk),
        .arst_n       (arst_n),
        .issue        (issue),
        .valid_id_ex  (valid_id_ex),
        .ready_id_ex  (ready_id_ex),
        .branch_flush (branch_flush),
        .mem_fwd      (mem_fwd),
        .wb_fwd       (wb_fwd),
        .cur          (cur),
        .cur_valid    (cur_valid),
        .op_a         (op_a),
        .op_b_reg     (op_b_reg)
    );

    exu_alu_branch u_alu (
        .cur       (cur),
        .op_a      (op_a),
        .op_b_reg  (op_b_reg),
        .alu_value (alu_value),
        .taken     (taken),
        .dnpc      (dnpc)
    );

    // divu and remu share one divider run
    assign is_div = (cur.op == exu_ctrl_pkg::OP_DIVU) || (cur.op == exu_ctrl_pkg::OP_REMU);
    // no start under back-pressure
    assign div_start   = cur_valid && is_div && ready_ex_mem;
    // stall until the quotient is ready
    assign div_pending = cur_valid && is_div && (div_state != exu_ctrl_pkg::DIV_DONE);

    div_ctrl_fsm u_div_fsm (
        .clk          (clk),
        .arst_n       (arst_n),
        .start        (div_start),
        .abort        (branch_flush),
        .last_step    (last_step),
        .ready_ex_mem (ready_ex_mem),
        .state        (div_state)
    );

    div_step_counter u_div_cnt (
        .clk       (clk),
        .arst_n    (arst_n),
        .state     (div_state),
        .last_step (last_step)
    );

    div_datapath u_div_dp (
        .clk       (clk),
        .arst_n    (arst_n),
        .state     (div_state),
        .dividend  (op_a),
        .divisor   (op_b_reg),
        .quotient  (quotient),
        .remainder (remainder)
    );

    // in DIV_DONE the next instruction enters with the transfer
    assign ready_id_ex  = ready_ex_mem && !div_pending;
    assign valid_ex_mem = cur_valid && !div_pending;
    // fetch redirect only once memory accepts the jump or branch
    assign pc_update    = cur_valid && ready_ex_mem && taken;

    always_comb begin
        result.pc = cur.pc;
        result.rd = cur.rd;
        case (cur.op)
            exu_ctrl_pkg::OP_DIVU: result.value = quotient;
            exu_ctrl_pkg::OP_REMU: result.value = remainder;
            default:               result.value = alu_value;
        endcase
    end

endmodule

// ==== sources.f ====
+incdir+logic
logic/exu_ctrl_pkg.sv
logic/exu_data_pkg.sv
logic/exu_operand_stage.sv
logic/exu_alu_branch.sv
logic/div_ctrl_fsm.sv
logic/div_step_counter.sv
logic/div_datapath.sv
logic/exu_top.sv
tb/exu_checker.sv
tb/exu_tb.sv

// ==== tb/exu_checker.sv ====
module exu_checker (
    input logic                     clk,
    input logic                     arst_n,
    input logic                     valid_ex_mem,
    input logic                     ready_ex_mem,
    input logic                     ready_id_ex,
    input logic                     pc_update,
    input exu_ctrl_pkg::div_state_t div_state
);
    timeunit 1ns;
    timeprecision 1ps;

    // number of failed assertions so far
    int fail_count = 0;

    // stage silent in reset and on the first edge after release
    reset_quiet: assert property (@(posedge clk)
        (!arst_n || $rose(arst_n)) |-> (!valid_ex_mem && !pc_update))
    else begin
        $error("valid_ex_mem or pc_update high during or right after reset");
        fail_count++;
    end

    // fetch redirect only together with an accepted transfer
    redirect_on_transfer: assert property (@(posedge clk) disable iff (!arst_n)
        pc_update |-> (valid_ex_mem && ready_ex_mem))
    else begin
        $error("pc_update without valid_ex_mem and ready_ex_mem");
        fail_count++;
    end

    // decode stalled for the whole divider run
    stall_in_div_run: assert property (@(posedge clk) disable iff (!arst_n)
        (div_state == exu_ctrl_pkg::DIV_RUN) |-> !ready_id_ex)
    else begin
        $error("ready_id_ex high while the divider is running");
        fail_count++;
    end

endmodule

bind exu_top exu_checker u_chk (
    .clk          (clk),
    .arst_n       (arst_n),
    .valid_ex_mem (valid_ex_mem),
    .ready_ex_mem (ready_ex_mem),
    .ready_id_ex  (ready_id_ex),
    .pc_update    (pc_update),
    .div_state    (div_state)
);

// ==== tb/exu_tb.sv ====
`include "exu_settings.svh"

module exu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int WAIT_LIMIT = 500;

    // expected response for one instruction
    typedef struct packed {
        exu_data_pkg::xlen_t value;
        logic                pc_update;
        exu_data_pkg::xlen_t dnpc;
    } expect_t;

    logic                  clk = 1'b0;
    logic                  arst_n;
    exu_data_pkg::issue_t  issue;
    logic                  valid_id_ex;
    logic                  ready_id_ex;
    exu_data_pkg::fwd_t    mem_fwd;
    exu_data_pkg::fwd_t    wb_fwd;
    logic                  branch_flush;
    exu_data_pkg::result_t result;
    logic                  valid_ex_mem;
    logic                  ready_ex_mem;
    logic                  pc_update;
    exu_data_pkg::xlen_t   dnpc;

    logic [31:0]           lfsr_state = 32'h3026;
    exu_data_pkg::xlen_t   next_pc = 64'h8000_0000;
    int                    hold_left = 0;
    logic                  bp_on = 1'b0;
    // accepted instructions in program order, oldest first
    exu_data_pkg::issue_t  pending[$];

    exu_top dut0 (
        .clk          (clk),
        .arst_n       (arst_n),
        .issue        (issue),
        .valid_id_ex  (valid_id_ex),
        .ready_id_ex  (ready_id_ex),
        .mem_fwd      (mem_fwd),
        .wb_fwd       (wb_fwd),
        .branch_flush (branch_flush),
        .result       (result),
        .valid_ex_mem (valid_ex_mem),
        .ready_ex_mem (ready_ex_mem),
        .pc_update    (pc_update),
        .dnpc         (dnpc)
    );

    always #4 clk = ~clk;

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            fail_now($sformatf("Error at %0t ns: %s = 0x%h, expected 0x%h",
                               $time, name, actual, expected));
        end
    endtask

    // galois lfsr, x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return out;
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[62:0], lfsr_bit()};
        end
        return r;
    endfunction

    // bypass per the forwarding rule, x0 never matches
    function automatic exu_data_pkg::xlen_t forwarded(input exu_data_pkg::reg_idx_t idx,
        input exu_data_pkg::xlen_t decoded, input exu_data_pkg::fwd_t mem,
        input exu_data_pkg::fwd_t wb);
        if (idx != 0 && mem.wen && mem.rd == idx) begin
            return mem.data;
        end
        if (idx != 0 && wb.wen && wb.rd == idx) begin
            return wb.data;
        end
        return decoded;
    endfunction

    function automatic expect_t exu_ref(input exu_data_pkg::issue_t it,
        input exu_data_pkg::fwd_t mem, input exu_data_pkg::fwd_t wb);
        exu_data_pkg::xlen_t a;
        exu_data_pkg::xlen_t b_reg;
        exu_data_pkg::xlen_t b;
        exu_data_pkg::xlen_t snpc;
        logic [5:0]          sh;
        logic                take;
        expect_t             e;
        a     = forwarded(it.rs1, it.src_a, mem, wb);
        b_reg = it.use_imm ? it.src_b : forwarded(it.rs2, it.src_b, mem, wb);
        b     = it.use_imm ? it.imm : b_reg;
        sh    = b[5:0];
        snpc  = it.pc + `EXU_PC_STEP;
        take  = 1'b0;
        e     = '0;
        case (it.op)
            exu_ctrl_pkg::OP_ADD:  e.value = a + b;
            exu_ctrl_pkg::OP_SUB:  e.value = a - b;
            exu_ctrl_pkg::OP_AND:  e.value = a & b;
            exu_ctrl_pkg::OP_OR:   e.value = a | b;
            exu_ctrl_pkg::OP_XOR:  e.value = a ^ b;
            exu_ctrl_pkg::OP_SLL:  e.value = a << sh;
            exu_ctrl_pkg::OP_SRL:  e.value = a >> sh;
            exu_ctrl_pkg::OP_SRA:  e.value = $signed(a) >>> sh;
            exu_ctrl_pkg::OP_SLT:  e.value = exu_data_pkg::xlen_t'($signed(a) < $signed(b));
            exu_ctrl_pkg::OP_SLTU: e.value = exu_data_pkg::xlen_t'(a < b);
            exu_ctrl_pkg::OP_BEQ:  take = (a == b_reg);
            exu_ctrl_pkg::OP_BNE:  take = (a != b_reg);
            exu_ctrl_pkg::OP_BLT:  take = ($signed(a) < $signed(b_reg));
            exu_ctrl_pkg::OP_BGE:  take = ($signed(a) >= $signed(b_reg));
            exu_ctrl_pkg::OP_BLTU: take = (a < b_reg);
            exu_ctrl_pkg::OP_BGEU: take = (a >= b_reg);
            exu_ctrl_pkg::OP_JAL, exu_ctrl_pkg::OP_JALR: begin
                take    = 1'b1;
                e.value = snpc;
            end
            // divide by zero gives all ones and keeps the dividend
            exu_ctrl_pkg::OP_DIVU: e.value = (b_reg == 0) ? '1 : a / b_reg;
            exu_ctrl_pkg::OP_REMU: e.value = (b_reg == 0) ? a : a % b_reg;
            default:               e.value = '0;
        endcase
        e.pc_update = take;
        if (it.op == exu_ctrl_pkg::OP_JALR) begin
            e.dnpc = a + it.imm;
        end else if (take) begin
            e.dnpc = it.pc + it.imm;
        end else begin
            e.dnpc = snpc;
        end
        return e;
    endfunction

    // small register indices so bypass hits are common
    function automatic exu_data_pkg::issue_t random_issue(input exu_ctrl_pkg::ex_op_t op);
        exu_data_pkg::issue_t it;
        logic [63:0]          imm12;
        it.pc      = next_pc;
        next_pc    = next_pc + `EXU_PC_STEP;
        it.op      = op;
        it.use_imm = lfsr_bit();
        if (op >= exu_ctrl_pkg::OP_BEQ && op != exu_ctrl_pkg::OP_JAL
                && op != exu_ctrl_pkg::OP_JALR) begin
            it.use_imm = 1'b0;
        end
        it.rd    = exu_data_pkg::reg_idx_t'(rand_bits(3));
        it.rs1   = exu_data_pkg::reg_idx_t'(rand_bits(3));
        it.rs2   = exu_data_pkg::reg_idx_t'(rand_bits(3));
        it.src_a = rand_bits(64);
        it.src_b = rand_bits(64);
        imm12    = rand_bits(12);
        it.imm   = {{52{imm12[11]}}, imm12[11:0]};
        // equal operands now and then, so branches go both ways
        if (rand_bits(2) == 0) begin
            it.src_b = it.src_a;
        end
        return it;
    endfunction

    function automatic exu_data_pkg::fwd_t random_fwd();
        exu_data_pkg::fwd_t f;
        f.wen  = lfsr_bit();
        f.rd   = exu_data_pkg::reg_idx_t'(rand_bits(3));
        f.data = rand_bits(64);
        return f;
    endfunction

    // memory back-pressure in random stretches of 1 to 8 cycles
    task automatic step_ready();
        if (!bp_on) begin
            ready_ex_mem = 1'b1;
        end else if (hold_left == 0) begin
            ready_ex_mem = !ready_ex_mem;
            hold_left    = int'(rand_bits(3));
        end else begin
            hold_left--;
        end
    endtask

    // decode side, holds the instruction until ready_id_ex
    task automatic send(input exu_data_pkg::issue_t item, input logic track);
        int waited;
        waited = 0;
        @(negedge clk);
        step_ready();
        issue       = item;
        valid_id_ex = 1'b1;
        @(posedge clk);
        while (!ready_id_ex) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                fail_now("timeout: the execute stage never accepted an instruction");
            end
            @(negedge clk);
            step_ready();
            @(posedge clk);
        end
        if (track) begin
            pending.push_back(item);
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        @(negedge clk);
        valid_id_ex = 1'b0;
        step_ready();
        while (pending.size() != 0) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                fail_now("timeout: issued instructions never reached the memory stage");
            end
            @(negedge clk);
            step_ready();
        end
    endtask

    task automatic send_div(input exu_ctrl_pkg::ex_op_t op, input logic [63:0] dividend,
                            input logic [63:0] divisor);
        exu_data_pkg::issue_t item;
        item       = random_issue(op);
        // x0 sources keep the bypass out of the way
        item.rs1   = '0;
        item.rs2   = '0;
        item.src_a = dividend;
        item.src_b = divisor;
        send(item, 1'b1);
    endtask

    // fixed bypass values per run, changed only when drained
    task automatic run_random(input int lo, input int span, input int count);
        logic [63:0] pick;
        mem_fwd = random_fwd();
        wb_fwd  = random_fwd();
        repeat (count) begin
            pick = lo + (rand_bits(5) % span);
            send(random_issue(exu_ctrl_pkg::ex_op_t'(pick[4:0])), 1'b1);
        end
        drain();
    endtask

    // every transfer matched against the oldest outstanding instruction
    always @(posedge clk) begin
        exu_data_pkg::issue_t exp_item;
        expect_t              exp;
        if (arst_n && valid_ex_mem && ready_ex_mem) begin
            if (pending.size() == 0) begin
                fail_now("a result reached the memory stage with no instruction outstanding");
            end
            exp_item = pending.pop_front();
            exp      = exu_ref(exp_item, mem_fwd, wb_fwd);
            check_value("result.pc", result.pc, exp_item.pc);
            check_value("result.rd", result.rd, exp_item.rd);
            check_value("result.value", result.value, exp.value);
            check_value("pc_update", pc_update, exp.pc_update);
            check_value("dnpc", dnpc, exp.dnpc);
        end else if (arst_n) begin
            check_value("pc_update", pc_update, 1'b0);
        end
    end

    // a failed bound assertion ends the run at once
    always @(negedge clk) begin
        if (dut0.u_chk.fail_count != 0) begin
            fail_now("the bound checker reported failed assertions");
        end
    end

    initial begin
        exu_data_pkg::issue_t item;
        arst_n       = 1'b0;
        issue        = '0;
        valid_id_ex  = 1'b0;
        mem_fwd      = '0;
        wb_fwd       = '0;
        branch_flush = 1'b0;
        ready_ex_mem = 1'b1;
        repeat (4) @(negedge clk);
        arst_n = 1'b1;

        // alu ops, then branches and jumps
        repeat (4) run_random(0, 10, 25);
        repeat (3) run_random(10, 8, 25);

        // both stages write x3, mem is younger and wins
        mem_fwd = '{1'b1, 5'd3, 64'h1111_2222_3333_4444};
        wb_fwd  = '{1'b1, 5'd3, 64'h5555_6666_7777_8888};
        item = random_issue(exu_ctrl_pkg::OP_ADD);
        item.use_imm = 1'b0;
        item.rs1     = 5'd3;
        item.rs2     = 5'd3;
        send(item, 1'b1);
        // immediate form, rs2 compare must see src_b, not the bypass
        item = random_issue(exu_ctrl_pkg::OP_BEQ);
        item.use_imm = 1'b1;
        item.rs1     = 5'd1;
        item.rs2     = 5'd3;
        item.src_b   = item.src_a;
        send(item, 1'b1);
        drain();
        // writes to x0 are never forwarded
        mem_fwd = '{1'b1, 5'd0, rand_bits(64)};
        wb_fwd  = '{1'b1, 5'd0, rand_bits(64)};
        item = random_issue(exu_ctrl_pkg::OP_OR);
        item.use_imm = 1'b0;
        item.rs1     = '0;
        item.rs2     = '0;
        send(item, 1'b1);
        drain();

        // division corners, back to back
        mem_fwd = '0;
        wb_fwd  = '0;
        send_div(exu_ctrl_pkg::OP_DIVU, 64'd100, 64'd7);
        send_div(exu_ctrl_pkg::OP_REMU, 64'd100, 64'd7);
        send_div(exu_ctrl_pkg::OP_DIVU, rand_bits(64), 64'd0);
        send_div(exu_ctrl_pkg::OP_REMU, rand_bits(64), 64'd0);
        send_div(exu_ctrl_pkg::OP_DIVU, 64'd3, 64'd1000);
        send_div(exu_ctrl_pkg::OP_REMU, 64'd3, 64'd1000);
        send_div(exu_ctrl_pkg::OP_DIVU, rand_bits(64), rand_bits(20));
        send_div(exu_ctrl_pkg::OP_REMU, rand_bits(64), rand_bits(64));
        drain();
        repeat (2) run_random(18, 2, 6);

        // everything mixed under back-pressure
        bp_on = 1'b1;
        repeat (4) run_random(0, 20, 20);
        bp_on = 1'b0;

        // flush kills a division mid-run
        mem_fwd = '0;
        wb_fwd  = '0;
        send(random_issue(exu_ctrl_pkg::OP_DIVU), 1'b0);
        @(negedge clk);
        valid_id_ex = 1'b0;
        repeat (8) begin
            @(posedge clk);
            check_value("valid_ex_mem", valid_ex_mem, 1'b0);
        end
        @(negedge clk);
        branch_flush = 1'b1;
        @(negedge clk);
        branch_flush = 1'b0;
        send(random_issue(exu_ctrl_pkg::OP_ADD), 1'b1);
        send(random_issue(exu_ctrl_pkg::OP_REMU), 1'b1);
        drain();

        if (dut0.u_chk.fail_count != 0) begin
            fail_now("the bound checker reported failed assertions");
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule
